/* hw/dispatchCfgPkg.sv */
package dispatchCfgPkg;

  // instructions delivered by rename in one bundle
  localparam int DISPATCH_WIDTH     = 4;
  localparam int DISPATCH_WIDTH_LOG = 2;

  // back-end structure capacities, all fixed at build time
  localparam int SIZE_ISSUEQ     = 32;
  localparam int SIZE_LSQ        = 16;
  localparam int SIZE_ACTIVELIST = 64;

  localparam int SIZE_PC = 32;

  // load violation predictor geometry
  // the index skips the two byte-offset bits of the PC
  localparam int LDVIO_ENTRIES = 16;
  localparam int LDVIO_IDX_LOG = 4;
  localparam int LDVIO_IDX_LSB = 2;

  typedef logic [SIZE_PC-1:0] pc_t;
  typedef logic [7:0]         seqNo_t;
  typedef logic [6:0]         phyReg_t;
  typedef logic [4:0]         logReg_t;
  typedef logic [5:0]         alId_t;
  typedef logic [3:0]         lsqId_t;

  // occupancy counts are one bit wider than the index so a full structure fits
  typedef logic [5:0] iqCnt_t;
  typedef logic [4:0] lsqCnt_t;
  typedef logic [6:0] alCnt_t;

  typedef logic [1:0] exePipe_t;
  typedef logic [3:0] excCause_t;

  // execution pipe numbering
  // pipes 2 and 3 both hold a simple ALU, only pipe 2 also has the complex unit
  localparam exePipe_t PIPE_MEM  = 2'd0;
  localparam exePipe_t PIPE_CTRL = 2'd1;
  localparam exePipe_t PIPE_ALU0 = 2'd2;
  localparam exePipe_t PIPE_ALU1 = 2'd3;

endpackage

/* hw/dispatchPktPkg.sv */
package dispatchPktPkg;

  import dispatchCfgPkg::*;

  // instruction class as decoded upstream, selects the execution pipe
  typedef enum logic [1:0] {
    FU_SIMPLE  = 2'd0,
    FU_COMPLEX = 2'd1,
    FU_CTRL    = 2'd2,
    FU_MEM     = 2'd3
  } fuType_t;

  // one renamed instruction as it leaves rename
  typedef struct packed {
    logic      valid;
    seqNo_t    seqNo;
    pc_t       pc;
    fuType_t   fu;
    logReg_t   logDest;
    phyReg_t   phyDest;
    logic      phyDestValid;
    phyReg_t   phySrc1;
    logic      phySrc1Valid;
    phyReg_t   phySrc2;
    logic      phySrc2Valid;
    logic [15:0] immed;
    logic      immedValid;
    logic      isLoad;
    logic      isStore;
    logic      exception;
    excCause_t exceptionCause;
  } disPkt_t;

  // issue queue entry, carries everything the wakeup and select logic needs
  typedef struct packed {
    logic        valid;
    seqNo_t      seqNo;
    pc_t         pc;
    exePipe_t    exePipe;
    logic        isSimple;
    logic        predLoadVio;
    phyReg_t     phySrc1;
    logic        phySrc1Valid;
    phyReg_t     phySrc2;
    logic        phySrc2Valid;
    logReg_t     logDest;
    phyReg_t     phyDest;
    logic        phyDestValid;
    logic [15:0] immed;
    logic        immedValid;
    alId_t       alId;
    lsqId_t      lsqId;
    logic        isLoad;
    logic        isStore;
  } iqPkt_t;

  // active list entry, keeps what retire needs to commit or roll back
  typedef struct packed {
    logic      valid;
    seqNo_t    seqNo;
    pc_t       pc;
    logReg_t   logDest;
    phyReg_t   phyDest;
    logic      phyDestValid;
    logic      isLoad;
    logic      isStore;
    logic      exception;
    excCause_t exceptionCause;
  } alPkt_t;

  typedef struct packed {
    logic   valid;
    seqNo_t seqNo;
    logic   isLoad;
    logic   isStore;
    logic   predLoadVio;
  } lsqPkt_t;

  // first excepting instruction of a bundle, written into the active list
  typedef struct packed {
    logic      valid;
    seqNo_t    seqNo;
    alId_t     alId;
    excCause_t exceptionCause;
  } excptPkt_t;

  // lane 0 is the oldest instruction of the bundle
  typedef disPkt_t [DISPATCH_WIDTH-1:0] disBundle_t;
  typedef iqPkt_t  [DISPATCH_WIDTH-1:0] iqBundle_t;
  typedef alPkt_t  [DISPATCH_WIDTH-1:0] alBundle_t;
  typedef lsqPkt_t [DISPATCH_WIDTH-1:0] lsqBundle_t;
  typedef alId_t   [DISPATCH_WIDTH-1:0] alIdBundle_t;
  typedef lsqId_t  [DISPATCH_WIDTH-1:0] lsqIdBundle_t;

endpackage

/* hw/resourceStallCheck.sv */
`timescale 1ns/100ps

module resourceStallCheck
  import dispatchCfgPkg::*;
(
  input  logic [DISPATCH_WIDTH-1:0] loadMask_i,
  input  logic [DISPATCH_WIDTH-1:0] storeMask_i,
  input  logic                      iqflRamReady_i,
  input  iqCnt_t                    issueQueueCnt_i,
  input  lsqCnt_t                   loadQueueCnt_i,
  input  lsqCnt_t                   storeQueueCnt_i,
  input  alCnt_t                    activeListCnt_i,
  output logic                      stall_o
);

  // one extra bit so a bundle made only of loads still fits
  logic [DISPATCH_WIDTH_LOG:0] loadCnt;
  logic [DISPATCH_WIDTH_LOG:0] storeCnt;

  logic iqStall;
  logic loadStall;
  logic storeStall;
  logic alStall;

  // population count of the load and store lanes
  always_comb
  begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++)
    begin
      loadCnt  = loadCnt + loadMask_i[i];
      storeCnt = storeCnt + storeMask_i[i];
    end
  end

  // the IQ and AL always reserve room for a full bundle
  // the comparisons are done at integer width so the sums cannot wrap
  // a free list RAM that is still busy blocks the IQ write as well
  assign iqStall    = ((issueQueueCnt_i + DISPATCH_WIDTH) > SIZE_ISSUEQ) || !iqflRamReady_i;
  assign alStall    = (activeListCnt_i + DISPATCH_WIDTH) > SIZE_ACTIVELIST;

  // the load and store queues only need room for what this bundle brings
  assign loadStall  = (loadQueueCnt_i + loadCnt) > SIZE_LSQ;
  assign storeStall = (storeQueueCnt_i + storeCnt) > SIZE_LSQ;

  assign stall_o = iqStall | alStall | loadStall | storeStall;

endmodule

/* hw/exePipeScheduler.sv */
`timescale 1ns/100ps

module exePipeScheduler
  import dispatchCfgPkg::*;
  import dispatchPktPkg::*;
(
  input  logic                          clk,
  input  logic                          rstN_i,
  input  logic                          recoverFlag_i,
  input  logic                          accept_i,
  input  fuType_t  [DISPATCH_WIDTH-1:0] fuTypes_i,
  output exePipe_t [DISPATCH_WIDTH-1:0] exePipe_o,
  output logic     [DISPATCH_WIDTH-1:0] isSimple_o
);

  // selects the ALU pipe for the first simple instruction of the bundle
  // a 0 sends it to PIPE_ALU0
  logic aluPtr;

  // pointer value after the last lane, loaded when the bundle is taken
  logic aluPtrNext;

  always_comb
  begin : pipeAssign
    logic ptr;

    ptr = aluPtr;
    for (int i = 0; i < DISPATCH_WIDTH; i++)
    begin
      isSimple_o[i] = (fuTypes_i[i] == FU_SIMPLE);
      case (fuTypes_i[i])
        FU_MEM:
          exePipe_o[i] = PIPE_MEM;
        FU_CTRL:
          exePipe_o[i] = PIPE_CTRL;
        // only the first ALU pipe has the multiplier and divider
        FU_COMPLEX:
          exePipe_o[i] = PIPE_ALU0;
        FU_SIMPLE:
        begin
          exePipe_o[i] = ptr ? PIPE_ALU1 : PIPE_ALU0;
          // the next simple lane goes to the other ALU
          ptr = ~ptr;
        end
        default:
          exePipe_o[i] = PIPE_ALU0;
      endcase
    end
    aluPtrNext = ptr;
  end

  // a stalled bundle is presented again next cycle and must see the same pointer
  // so the register only moves when the bundle is accepted
  // recovery flushes everything younger, so steering restarts from the first ALU
  always_ff @(posedge clk)
  begin
    if (!rstN_i || recoverFlag_i)
    begin
      aluPtr <= 1'b0;
    end
    else if (accept_i)
    begin
      aluPtr <= aluPtrNext;
    end
  end

endmodule

/* hw/loadViolationPred.sv */
`timescale 1ns/100ps

module loadViolationPred
  import dispatchCfgPkg::*;
  import dispatchPktPkg::*;
(
  input  logic                      clk,
  input  logic                      rstN_i,
  input  logic                      loadViolation_i,
  input  logic                      recoverFlag_i,
  input  pc_t                       recoverPc_i,
  input  pc_t [DISPATCH_WIDTH-1:0]  pcs_i,
  input  logic [DISPATCH_WIDTH-1:0] loadMask_i,
  output logic [DISPATCH_WIDTH-1:0] predLoadVio_o
);

  // one bit per entry, set once a load at that index broke memory ordering
  // entries are never cleared except by reset, so the table only gets more cautious
  logic [LDVIO_ENTRIES-1:0] vioTable;

  // word-aligned PC bits select the entry
  function automatic logic [LDVIO_IDX_LOG-1:0] vioIndex(input pc_t pc);
    return pc[LDVIO_IDX_LSB +: LDVIO_IDX_LOG];
  endfunction

  // a violation is reported together with the recovery it causes
  // and the recovery PC is the PC of the offending load
  always_ff @(posedge clk)
  begin
    if (!rstN_i)
    begin
      vioTable <= '0;
    end
    else if (loadViolation_i && recoverFlag_i)
    begin
      vioTable[vioIndex(recoverPc_i)] <= 1'b1;
    end
  end

  // a predicted load waits at issue for older stores
  always_comb
  begin
    for (int i = 0; i < DISPATCH_WIDTH; i++)
    begin
      predLoadVio_o[i] = loadMask_i[i] & vioTable[vioIndex(pcs_i[i])];
    end
  end

endmodule

/* hw/dispatchPacketBuild.sv */
`timescale 1ns/100ps

module dispatchPacketBuild
  import dispatchCfgPkg::*;
  import dispatchPktPkg::*;
(
  input  disBundle_t                     disBundle_i,
  input  alIdBundle_t                    alId_i,
  input  lsqIdBundle_t                   lsqId_i,
  input  logic                           stall_i,
  input  exePipe_t [DISPATCH_WIDTH-1:0]  exePipe_i,
  input  logic     [DISPATCH_WIDTH-1:0]  isSimple_i,
  input  logic     [DISPATCH_WIDTH-1:0]  predLoadVio_i,
  output iqBundle_t                      iqBundle_o,
  output alBundle_t                      alBundle_o,
  output lsqBundle_t                     lsqBundle_o,
  output excptPkt_t                      excptPkt_o
);

  // valid lanes that carry an exception from the front end
  logic [DISPATCH_WIDTH-1:0] excVec;

  // lowest excepting lane, lane 0 when there is none
  logic [DISPATCH_WIDTH_LOG-1:0] excLane;

  // issue queue packets
  // an excepting instruction never executes, so it is kept out of the IQ
  always_comb
  begin
    for (int i = 0; i < DISPATCH_WIDTH; i++)
    begin
      iqBundle_o[i].valid        = disBundle_i[i].valid & ~stall_i & ~disBundle_i[i].exception;
      iqBundle_o[i].seqNo        = disBundle_i[i].seqNo;
      iqBundle_o[i].pc           = disBundle_i[i].pc;
      iqBundle_o[i].exePipe      = exePipe_i[i];
      iqBundle_o[i].isSimple     = isSimple_i[i];
      iqBundle_o[i].predLoadVio  = predLoadVio_i[i];
      iqBundle_o[i].phySrc1      = disBundle_i[i].phySrc1;
      iqBundle_o[i].phySrc1Valid = disBundle_i[i].phySrc1Valid;
      iqBundle_o[i].phySrc2      = disBundle_i[i].phySrc2;
      iqBundle_o[i].phySrc2Valid = disBundle_i[i].phySrc2Valid;
      iqBundle_o[i].logDest      = disBundle_i[i].logDest;
      iqBundle_o[i].phyDest      = disBundle_i[i].phyDest;
      iqBundle_o[i].phyDestValid = disBundle_i[i].phyDestValid;
      iqBundle_o[i].immed        = disBundle_i[i].immed;
      iqBundle_o[i].immedValid   = disBundle_i[i].immedValid;
      iqBundle_o[i].alId         = alId_i[i];
      iqBundle_o[i].lsqId        = lsqId_i[i];
      iqBundle_o[i].isLoad       = disBundle_i[i].isLoad;
      iqBundle_o[i].isStore      = disBundle_i[i].isStore;
    end
  end

  // active list packets
  // excepting lanes are still written so retire can raise the exception in order
  always_comb
  begin
    for (int i = 0; i < DISPATCH_WIDTH; i++)
    begin
      alBundle_o[i].valid          = disBundle_i[i].valid & ~stall_i;
      alBundle_o[i].seqNo          = disBundle_i[i].seqNo;
      alBundle_o[i].pc             = disBundle_i[i].pc;
      alBundle_o[i].logDest        = disBundle_i[i].logDest;
      alBundle_o[i].phyDest        = disBundle_i[i].phyDest;
      alBundle_o[i].phyDestValid   = disBundle_i[i].phyDestValid;
      alBundle_o[i].isLoad         = disBundle_i[i].isLoad;
      alBundle_o[i].isStore        = disBundle_i[i].isStore;
      alBundle_o[i].exception      = disBundle_i[i].exception;
      alBundle_o[i].exceptionCause = disBundle_i[i].exceptionCause;
    end
  end

  // load/store queue packets follow the same rule as the IQ
  always_comb
  begin
    for (int i = 0; i < DISPATCH_WIDTH; i++)
    begin
      lsqBundle_o[i].valid       = disBundle_i[i].valid & ~stall_i & ~disBundle_i[i].exception;
      lsqBundle_o[i].seqNo       = disBundle_i[i].seqNo;
      lsqBundle_o[i].isLoad      = disBundle_i[i].isLoad;
      lsqBundle_o[i].isStore     = disBundle_i[i].isStore;
      lsqBundle_o[i].predLoadVio = predLoadVio_i[i];
    end
  end

  // priority encoder, scanning down so the oldest excepting lane wins
  always_comb
  begin
    excLane = '0;
    for (int i = DISPATCH_WIDTH - 1; i >= 0; i--)
    begin
      excVec[i] = disBundle_i[i].valid & disBundle_i[i].exception;
      if (excVec[i])
      begin
        excLane = DISPATCH_WIDTH_LOG'(i);
      end
    end
  end

  // held back under stall, otherwise it would reach the AL before its entry does
  assign excptPkt_o.valid          = (|excVec) & ~stall_i;
  assign excptPkt_o.seqNo          = disBundle_i[excLane].seqNo;
  assign excptPkt_o.alId           = alId_i[excLane];
  assign excptPkt_o.exceptionCause = disBundle_i[excLane].exceptionCause;

endmodule

/* hw/dispatch.sv */
`timescale 1ns/100ps

module dispatch
  import dispatchCfgPkg::*;
  import dispatchPktPkg::*;
(
  input  logic         clk,
  input  logic         rstN_i,
  input  disBundle_t   disBundle_i,
  input  alIdBundle_t  alId_i,
  input  lsqIdBundle_t lsqId_i,
  input  logic         renameReady_i,
  input  logic         iqflRamReady_i,
  input  iqCnt_t       issueQueueCnt_i,
  input  lsqCnt_t      loadQueueCnt_i,
  input  lsqCnt_t      storeQueueCnt_i,
  input  alCnt_t       activeListCnt_i,
  input  logic         recoverFlag_i,
  input  pc_t          recoverPc_i,
  input  logic         loadViolation_i,
  output iqBundle_t    iqBundle_o,
  output alBundle_t    alBundle_o,
  output lsqBundle_t   lsqBundle_o,
  output excptPkt_t    excptPkt_o,
  output logic         dispatchReady_o,
  output logic         backEndFull_o
);

  logic [DISPATCH_WIDTH-1:0]     loadMask;
  logic [DISPATCH_WIDTH-1:0]     storeMask;
  pc_t     [DISPATCH_WIDTH-1:0]  pcs;
  fuType_t [DISPATCH_WIDTH-1:0]  fuTypes;

  logic                          stall;
  exePipe_t [DISPATCH_WIDTH-1:0] exePipe;
  logic [DISPATCH_WIDTH-1:0]     isSimple;
  logic [DISPATCH_WIDTH-1:0]     predLoadVio;

  // pull the per-lane fields the submodules need out of the bundle
  // invalid lanes may hold stale isLoad and isStore bits, so the masks are qualified
  always_comb
  begin
    for (int i = 0; i < DISPATCH_WIDTH; i++)
    begin
      loadMask[i]  = disBundle_i[i].valid & disBundle_i[i].isLoad;
      storeMask[i] = disBundle_i[i].valid & disBundle_i[i].isStore;
      pcs[i]       = disBundle_i[i].pc;
      fuTypes[i]   = disBundle_i[i].fu;
    end
  end

  resourceStallCheck u_stallCheck (
    .loadMask_i      (loadMask),
    .storeMask_i     (storeMask),
    .iqflRamReady_i  (iqflRamReady_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .stall_o         (stall)
  );

  // the back end writes IQ, LSQ and AL only when rename has a bundle and there is room
  assign dispatchReady_o = ~stall & renameReady_i;
  // instruction buffer and rename hold their bundle while this is high
  assign backEndFull_o   = stall;

  exePipeScheduler u_pipeSched (
    .clk           (clk),
    .rstN_i        (rstN_i),
    .recoverFlag_i (recoverFlag_i),
    .accept_i      (dispatchReady_o),
    .fuTypes_i     (fuTypes),
    .exePipe_o     (exePipe),
    .isSimple_o    (isSimple)
  );

  loadViolationPred u_ldVioPred (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .loadViolation_i (loadViolation_i),
    .recoverFlag_i   (recoverFlag_i),
    .recoverPc_i     (recoverPc_i),
    .pcs_i           (pcs),
    .loadMask_i      (loadMask),
    .predLoadVio_o   (predLoadVio)
  );

  dispatchPacketBuild u_pktBuild (
    .disBundle_i   (disBundle_i),
    .alId_i        (alId_i),
    .lsqId_i       (lsqId_i),
    .stall_i       (stall),
    .exePipe_i     (exePipe),
    .isSimple_i    (isSimple),
    .predLoadVio_i (predLoadVio),
    .iqBundle_o    (iqBundle_o),
    .alBundle_o    (alBundle_o),
    .lsqBundle_o   (lsqBundle_o),
    .excptPkt_o    (excptPkt_o)
  );

endmodule

/* tb/dispatch_assertions.sv */
`timescale 1ns/100ps

module dispatch_assertions
  import dispatchCfgPkg::*;
  import dispatchPktPkg::*;
(
  input logic       clk,
  input logic       rstN_i,
  input logic       renameReady_i,
  input disBundle_t disBundle_i,
  input iqBundle_t  iqBundle_o,
  input alBundle_t  alBundle_o,
  input lsqBundle_t lsqBundle_o,
  input logic       dispatchReady_o,
  input logic       backEndFull_o
);

  // read by the testbench at the end of the run
  int assertFails = 0;

  logic [DISPATCH_WIDTH-1:0] iqValid;
  logic [DISPATCH_WIDTH-1:0] alValid;
  logic [DISPATCH_WIDTH-1:0] lsqValid;
  logic [DISPATCH_WIDTH-1:0] excBits;

  always_comb
  begin
    for (int i = 0; i < DISPATCH_WIDTH; i++)
    begin
      iqValid[i]  = iqBundle_o[i].valid;
      alValid[i]  = alBundle_o[i].valid;
      lsqValid[i] = lsqBundle_o[i].valid;
      excBits[i]  = disBundle_i[i].exception;
    end
  end

  // nothing may be written into a full back end
  noWriteWhenFull: assert property (@(posedge clk) disable iff (!rstN_i)
    backEndFull_o |-> ((iqValid | alValid | lsqValid) == '0))
  else
  begin
    assertFails++;
    $error("packet valid while the back end is full");
  end

  readyRule: assert property (@(posedge clk) disable iff (!rstN_i)
    dispatchReady_o == (!backEndFull_o && renameReady_i))
  else
  begin
    assertFails++;
    $error("dispatch ready disagrees with back-end full and rename ready");
  end

  // an excepting instruction is kept out of the issue queue
  noExcInIq: assert property (@(posedge clk) disable iff (!rstN_i)
    (iqValid & excBits) == '0)
  else
  begin
    assertFails++;
    $error("issue queue packet valid on an excepting lane");
  end

endmodule

bind dispatch dispatch_assertions u_dispAsserts (
  .clk             (clk),
  .rstN_i          (rstN_i),
  .renameReady_i   (renameReady_i),
  .disBundle_i     (disBundle_i),
  .iqBundle_o      (iqBundle_o),
  .alBundle_o      (alBundle_o),
  .lsqBundle_o     (lsqBundle_o),
  .dispatchReady_o (dispatchReady_o),
  .backEndFull_o   (backEndFull_o)
);

/* tb/dispatchRefModel.svh */
`ifndef DISPATCH_REF_MODEL_SVH
`define DISPATCH_REF_MODEL_SVH

// the back end is full when any structure cannot take the whole bundle
// IQ and AL always reserve a full bundle, the LSQ only what the valid lanes bring
function automatic logic needStall(input disBundle_t b, input logic ramReady, input int iqCnt,
                                   input int ldCnt, input int stCnt, input int alCnt);
  int loads;
  int stores;

  loads  = 0;
  stores = 0;
  for (int i = 0; i < DISPATCH_WIDTH; i++)
  begin
    if (b[i].valid && b[i].isLoad)
      loads++;
    if (b[i].valid && b[i].isStore)
      stores++;
  end
  return (iqCnt + DISPATCH_WIDTH > SIZE_ISSUEQ) || !ramReady ||
         (ldCnt + loads > SIZE_LSQ) || (stCnt + stores > SIZE_LSQ) ||
         (alCnt + DISPATCH_WIDTH > SIZE_ACTIVELIST);
endfunction

// memory to pipe 0, control to pipe 1, complex to pipe 2
// simple lanes alternate between pipes 2 and 3, every simple lane flips the pointer
// returns the pointer value seen after the last lane
function automatic logic routePipes(input disBundle_t b, input logic ptrIn,
                                    output exePipe_t [DISPATCH_WIDTH-1:0] pipes,
                                    output logic [DISPATCH_WIDTH-1:0] simple);
  logic ptr;

  ptr = ptrIn;
  for (int i = 0; i < DISPATCH_WIDTH; i++)
  begin
    simple[i] = (b[i].fu == FU_SIMPLE);
    case (b[i].fu)
      FU_MEM:     pipes[i] = 2'd0;
      FU_CTRL:    pipes[i] = 2'd1;
      FU_COMPLEX: pipes[i] = 2'd2;
      default:
      begin
        pipes[i] = ptr ? 2'd3 : 2'd2;
        ptr = ~ptr;
      end
    endcase
  end
  return ptr;
endfunction

// a valid load is predicted when the table bit at PC bits 5 to 2 is set
function automatic logic [DISPATCH_WIDTH-1:0] predictLoadVio(input disBundle_t b,
                                                             input logic [15:0] vioTable);
  logic [DISPATCH_WIDTH-1:0] pred;

  for (int i = 0; i < DISPATCH_WIDTH; i++)
    pred[i] = b[i].valid & b[i].isLoad & vioTable[b[i].pc[5:2]];
  return pred;
endfunction

// oldest valid excepting lane, or -1 when the bundle has none
function automatic int firstExcLane(input disBundle_t b);
  for (int i = 0; i < DISPATCH_WIDTH; i++)
  begin
    if (b[i].valid && b[i].exception)
      return i;
  end
  return -1;
endfunction

`endif

/* tb/dispatchTb.sv */
`timescale 1ns/100ps

module dispatchTb
  import dispatchCfgPkg::*;
  import dispatchPktPkg::*;
();

  `include "dispatchRefModel.svh"

  typedef enum {STALL_SWEEP, PIPE_ROUTE, FIELD_PASS, EXC_SELECT, LOAD_VIO} testMode_t;

  // test lengths in cycles
  // the watchdog limit adds the reset cycles and a margin on top
  localparam int LEN_STALL = 80;
  localparam int LEN_PIPE  = 80;
  localparam int LEN_PASS  = 40;
  localparam int LEN_EXC   = 60;
  localparam int LEN_VIO   = 60;
  localparam int TIMEOUT_CYCLES = 2 + LEN_STALL + LEN_PIPE + LEN_PASS + LEN_EXC + LEN_VIO + 20;

  logic clk;
  logic rstN_i;
  disBundle_t disBundle_i;
  alIdBundle_t alId_i;
  lsqIdBundle_t lsqId_i;
  logic renameReady_i;
  logic iqflRamReady_i;
  iqCnt_t issueQueueCnt_i;
  lsqCnt_t loadQueueCnt_i;
  lsqCnt_t storeQueueCnt_i;
  alCnt_t activeListCnt_i;
  logic recoverFlag_i;
  pc_t recoverPc_i;
  logic loadViolation_i;
  iqBundle_t iqBundle_o;
  alBundle_t alBundle_o;
  lsqBundle_t lsqBundle_o;
  excptPkt_t excptPkt_o;
  logic dispatchReady_o;
  logic backEndFull_o;

  string testName = "reset";
  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;
  logic [31:0] lcgState = 32'h1e4a;

  // model copies of the scheduler pointer and the predictor table
  logic ptrModel;
  logic [LDVIO_ENTRIES-1:0] vioModel;

  dispatch uut (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function logic [31:0] lcgRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic checkValue(input string what, input logic [127:0] expected,
                            input logic [127:0] actual);
    checkCount++;
    if (expected !== actual)
    begin
      errorCount++;
      $display("FAILED %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  // each lane is valid three times in four on average
  // memory-heavy bundles favour loads and stores
  // the small PC pool makes predictor indices repeat
  task automatic makeBundle(input bit memHeavy, input bit withExc, input bit smallPcs,
                            output disBundle_t b);
    logic [31:0] r;

    for (int i = 0; i < DISPATCH_WIDTH; i++)
    begin
      r = lcgRand();
      b[i].valid          = (r[31:30] != 2'b00);
      b[i].fu             = (memHeavy && r[29]) ? FU_MEM : fuType_t'(r[28:27]);
      b[i].isLoad         = (b[i].fu == FU_MEM) & r[26];
      b[i].isStore        = (b[i].fu == FU_MEM) & ~r[26];
      b[i].exception      = withExc & (r[25:24] == 2'b00);
      b[i].exceptionCause = r[23:20];
      b[i].seqNo          = r[19:12];
      b[i].immedValid     = r[11];
      b[i].phyDestValid   = r[10];
      b[i].phySrc1Valid   = r[9];
      b[i].phySrc2Valid   = r[8];
      b[i].logDest        = r[7:3];
      r = lcgRand();
      b[i].phyDest        = r[6:0];
      b[i].phySrc1        = r[13:7];
      b[i].phySrc2        = r[20:14];
      b[i].immed          = {r[31:21], r[4:0]};
      r = lcgRand();
      b[i].pc             = smallPcs ? 32'h1000 + (r[31:29] << 2) : {r[31:2], 2'b00};
    end
  endtask

  task automatic runTest(input string name, input int cycles, input testMode_t mode);
    disBundle_t b;
    alIdBundle_t ids;
    lsqIdBundle_t lsqIds;
    logic [31:0] r;
    logic [1:0] sel;

    testName = name;
    for (int c = 0; c < cycles; c++)
    begin
      @(posedge clk);
      makeBundle(mode == STALL_SWEEP || mode == LOAD_VIO, mode == EXC_SELECT,
                 mode == LOAD_VIO, b);
      r = lcgRand();
      sel = (mode == STALL_SWEEP) ? r[23:22] : 2'd0;
      for (int i = 0; i < DISPATCH_WIDTH; i++)
      begin
        ids[i]    = alId_t'(r[29:24] + i);
        lsqIds[i] = lsqId_t'(r[31:28] + i);
      end
      disBundle_i <= b;
      alId_i      <= ids;
      lsqId_i     <= lsqIds;
      // in the sweep one structure at a time sits at the edge of its capacity
      if (mode == STALL_SWEEP && sel == 2'd0)
        issueQueueCnt_i <= iqCnt_t'(SIZE_ISSUEQ - DISPATCH_WIDTH - 1 + r[9:8]);
      else
        issueQueueCnt_i <= iqCnt_t'(r[3:0]);
      if (mode == STALL_SWEEP && sel == 2'd1)
        loadQueueCnt_i <= lsqCnt_t'(SIZE_LSQ - 3 + r[11:10]);
      else
        loadQueueCnt_i <= lsqCnt_t'(r[6:4]);
      if (mode == STALL_SWEEP && sel == 2'd2)
        storeQueueCnt_i <= lsqCnt_t'(SIZE_LSQ - 3 + r[13:12]);
      else
        storeQueueCnt_i <= lsqCnt_t'(r[7:5]);
      if (mode == STALL_SWEEP && sel == 2'd3)
        activeListCnt_i <= alCnt_t'(SIZE_ACTIVELIST - DISPATCH_WIDTH - 1 + r[15:14]);
      else
        activeListCnt_i <= alCnt_t'(r[5:0]);
      // refused bundles only show up where the pointer hold matters
      iqflRamReady_i  <= (mode == STALL_SWEEP || mode == PIPE_ROUTE) ? (r[18:16] != 3'd0) : 1'b1;
      renameReady_i   <= (mode == STALL_SWEEP || mode == PIPE_ROUTE) ? (r[19] | r[20]) : 1'b1;
      // violations are signalled on the PC of the oldest lane of the bundle
      recoverFlag_i   <= (mode == PIPE_ROUTE && c % 13 == 12) || (mode == LOAD_VIO && c % 6 == 5);
      loadViolation_i <= (mode == LOAD_VIO && c % 6 == 5);
      recoverPc_i     <= b[0].pc;
    end
  endtask

  // the DUT inputs only move at rising edges
  // so the outputs have settled by the falling edge
  always @(negedge clk)
  begin : compareOutputs
    logic stallExp;
    logic readyExp;
    logic nextPtr;
    exePipe_t [DISPATCH_WIDTH-1:0] pipesExp;
    logic [DISPATCH_WIDTH-1:0] simpleExp;
    logic [DISPATCH_WIDTH-1:0] predExp;
    int lane;
    iqPkt_t iqExp;
    alPkt_t alExp;
    lsqPkt_t lsqExp;
    excptPkt_t excExp;

    if (rstN_i !== 1'b1)
    begin
      ptrModel = 1'b0;
      vioModel = '0;
    end
    else
    begin
      stallExp = needStall(disBundle_i, iqflRamReady_i, issueQueueCnt_i, loadQueueCnt_i,
                           storeQueueCnt_i, activeListCnt_i);
      readyExp = !stallExp && renameReady_i;
      nextPtr  = routePipes(disBundle_i, ptrModel, pipesExp, simpleExp);
      predExp  = predictLoadVio(disBundle_i, vioModel);
      lane     = firstExcLane(disBundle_i);
      checkValue("backEndFull", stallExp, backEndFull_o);
      checkValue("dispatchReady", readyExp, dispatchReady_o);
      for (int i = 0; i < DISPATCH_WIDTH; i++)
      begin
        iqExp.valid        = disBundle_i[i].valid && !stallExp && !disBundle_i[i].exception;
        iqExp.seqNo        = disBundle_i[i].seqNo;
        iqExp.pc           = disBundle_i[i].pc;
        iqExp.exePipe      = pipesExp[i];
        iqExp.isSimple     = simpleExp[i];
        iqExp.predLoadVio  = predExp[i];
        iqExp.phySrc1      = disBundle_i[i].phySrc1;
        iqExp.phySrc1Valid = disBundle_i[i].phySrc1Valid;
        iqExp.phySrc2      = disBundle_i[i].phySrc2;
        iqExp.phySrc2Valid = disBundle_i[i].phySrc2Valid;
        iqExp.logDest      = disBundle_i[i].logDest;
        iqExp.phyDest      = disBundle_i[i].phyDest;
        iqExp.phyDestValid = disBundle_i[i].phyDestValid;
        iqExp.immed        = disBundle_i[i].immed;
        iqExp.immedValid   = disBundle_i[i].immedValid;
        iqExp.alId         = alId_i[i];
        iqExp.lsqId        = lsqId_i[i];
        iqExp.isLoad       = disBundle_i[i].isLoad;
        iqExp.isStore      = disBundle_i[i].isStore;
        checkValue($sformatf("iq lane %0d", i), iqExp, iqBundle_o[i]);
        alExp.valid          = disBundle_i[i].valid && !stallExp;
        alExp.seqNo          = disBundle_i[i].seqNo;
        alExp.pc             = disBundle_i[i].pc;
        alExp.logDest        = disBundle_i[i].logDest;
        alExp.phyDest        = disBundle_i[i].phyDest;
        alExp.phyDestValid   = disBundle_i[i].phyDestValid;
        alExp.isLoad         = disBundle_i[i].isLoad;
        alExp.isStore        = disBundle_i[i].isStore;
        alExp.exception      = disBundle_i[i].exception;
        alExp.exceptionCause = disBundle_i[i].exceptionCause;
        checkValue($sformatf("al lane %0d", i), alExp, alBundle_o[i]);
        lsqExp.valid       = iqExp.valid;
        lsqExp.seqNo       = disBundle_i[i].seqNo;
        lsqExp.isLoad      = disBundle_i[i].isLoad;
        lsqExp.isStore     = disBundle_i[i].isStore;
        lsqExp.predLoadVio = predExp[i];
        checkValue($sformatf("lsq lane %0d", i), lsqExp, lsqBundle_o[i]);
      end
      excExp.valid = (lane >= 0) && !stallExp;
      if (lane < 0)
        lane = 0;
      excExp.seqNo          = disBundle_i[lane].seqNo;
      excExp.alId           = alId_i[lane];
      excExp.exceptionCause = disBundle_i[lane].exceptionCause;
      checkValue("exception packet", excExp, excptPkt_o);
      // state seen by the DUT after the coming rising edge
      if (recoverFlag_i)
        ptrModel = 1'b0;
      else if (readyExp)
        ptrModel = nextPtr;
      if (recoverFlag_i && loadViolation_i)
        vioModel[recoverPc_i[5:2]] = 1'b1;
    end
  end

  initial
  begin : watchdog
    while (cycleCount < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial
  begin : mainSequence
    int totalErrors;

    rstN_i          = 1'b0;
    disBundle_i     = '0;
    alId_i          = '0;
    lsqId_i         = '0;
    renameReady_i   = 1'b0;
    iqflRamReady_i  = 1'b1;
    issueQueueCnt_i = '0;
    loadQueueCnt_i  = '0;
    storeQueueCnt_i = '0;
    activeListCnt_i = '0;
    recoverFlag_i   = 1'b0;
    recoverPc_i     = '0;
    loadViolation_i = 1'b0;
    repeat (2) @(posedge clk);
    rstN_i <= 1'b1;
    runTest("stall", LEN_STALL, STALL_SWEEP);
    runTest("pipe", LEN_PIPE, PIPE_ROUTE);
    runTest("passthrough", LEN_PASS, FIELD_PASS);
    runTest("exception", LEN_EXC, EXC_SELECT);
    runTest("loadvio", LEN_VIO, LOAD_VIO);
    @(posedge clk);
    @(negedge clk);
    #1;
    totalErrors = errorCount + uut.u_dispAsserts.assertFails;
    $display("%0d checks, %0d errors", checkCount, totalErrors);
    if (totalErrors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* list.f */
+incdir+tb
hw/dispatchCfgPkg.sv
hw/dispatchPktPkg.sv
hw/resourceStallCheck.sv
hw/exePipeScheduler.sv
hw/loadViolationPred.sv
hw/dispatchPacketBuild.sv
hw/dispatch.sv
tb/dispatch_assertions.sv
tb/dispatchTb.sv

/* Bender.yml */
package:
  name: dispatch

sources:
  - files:
      - hw/dispatchCfgPkg.sv
      - hw/dispatchPktPkg.sv
      - hw/resourceStallCheck.sv
      - hw/exePipeScheduler.sv
      - hw/loadViolationPred.sv
      - hw/dispatchPacketBuild.sv
      - hw/dispatch.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/dispatch_assertions.sv
      - tb/dispatchTb.sv
